/* mackbd_pkg.sv */
package mackbd_pkg;

	localparam int BYTE_W = 8;
	localparam int CODE_W = 7;
	localparam int SCAN_W = BYTE_W + 1;         // Extended flag on top of the scan byte

	typedef logic [BYTE_W-1:0] byte_t;
	typedef logic [CODE_W-1:0] mac_code_t;
	typedef logic [SCAN_W-1:0] scan_t;

	// PS/2 keyboard protocol bytes
	localparam byte_t PS2_BAT_OK   = 8'haa;     // Self-test passed
	localparam byte_t PS2_ACK      = 8'hfa;
	localparam byte_t PS2_RELEASE  = 8'hf0;     // Break prefix
	localparam byte_t PS2_EXTEND   = 8'he0;
	localparam byte_t PS2_SET_LEDS = 8'hed;
	localparam byte_t PS2_RESET    = 8'hff;

	localparam byte_t SCAN_CAPSLOCK = 8'h58;

	// LED byte layout, num lock is always lit
	localparam int NUM_LED_BIT  = 1;
	localparam int CAPS_LED_BIT = 2;

	// Commands from the Mac
	localparam byte_t MAC_CMD_INQUIRY = 8'h10;
	localparam byte_t MAC_CMD_INSTANT = 8'h14;
	localparam byte_t MAC_CMD_MODEL   = 8'h16;
	localparam byte_t MAC_CMD_TEST    = 8'h36;

	// Replies to the Mac
	localparam byte_t MAC_MODEL_REPLY = 8'h03;
	localparam byte_t MAC_TEST_ACK    = 8'h7d;
	localparam byte_t MAC_NULL        = 8'h7b;

	localparam int RELEASE_BIT = 7;             // Set in a reply for a key going up

	// Key number that encodes as the null reply
	localparam mac_code_t MAC_KEY_NULL = 7'h3d;

	typedef enum logic [1:0] {
		INIT,
		LED_CMD,
		LED_VAL,
		READY
	} link_state_t;

endpackage

/* key_if.sv */
interface key_if;

	logic                  pending;    // A translated key waits for the Mac
	mackbd_pkg::mac_code_t code;
	logic                  released;   // Key went up
	logic                  pop;        // Consumer takes or flushes the key

	modport driver (
		output pending,
		output code,
		output released,
		input  pop
	);

	modport consumer (
		input  pending,
		input  code,
		input  released,
		output pop
	);

endinterface

/* ps2_link_ctrl.sv */
module ps2_link_ctrl (
	input  logic                sysclk,
	input  logic                reset,
	input  logic                ps2_strobe,
	input  mackbd_pkg::byte_t   ps2_byte,
	input  logic                ps2_timeout,
	input  logic                capslock,
	output logic                ps2_req,
	output mackbd_pkg::byte_t   ps2_send_byte,
	output logic                link_ready
);

	mackbd_pkg::link_state_t state;
	mackbd_pkg::link_state_t state_next;
	logic                    req_next;
	mackbd_pkg::byte_t       byte_next;
	mackbd_pkg::byte_t       led_byte;
	logic                    link_event;
	logic                    got_bat;
	logic                    got_ack;

	assign link_event = ps2_strobe || ps2_timeout;
	assign got_bat    = ps2_strobe && (ps2_byte == mackbd_pkg::PS2_BAT_OK);
	assign got_ack    = ps2_strobe && (ps2_byte == mackbd_pkg::PS2_ACK);
	assign link_ready = (state == mackbd_pkg::READY);

	always_comb begin
		led_byte = '0;
		led_byte[mackbd_pkg::NUM_LED_BIT]  = 1'b1;
		led_byte[mackbd_pkg::CAPS_LED_BIT] = capslock;
	end

	always_comb begin
		state_next = state;
		req_next   = 1'b0;
		byte_next  = mackbd_pkg::PS2_RESET;     // Default answer to anything unexpected
		if (link_event) begin
			case (state)
				mackbd_pkg::INIT: begin
					if (got_bat) begin
						req_next   = 1'b1;
						byte_next  = mackbd_pkg::PS2_SET_LEDS;
						state_next = mackbd_pkg::LED_CMD;
					end else if (!got_ack) begin
						req_next = 1'b1;                // Stray ack is tolerated
					end
				end
				mackbd_pkg::LED_CMD: begin
					req_next = 1'b1;
					if (got_ack) begin
						byte_next  = led_byte;
						state_next = mackbd_pkg::LED_VAL;
					end else begin
						state_next = mackbd_pkg::INIT;
					end
				end
				mackbd_pkg::LED_VAL: begin
					if (got_ack) begin
						state_next = mackbd_pkg::READY;
					end else begin
						req_next   = 1'b1;
						state_next = mackbd_pkg::INIT;
					end
				end
				default: begin
				end                                     // READY, key traffic only
			endcase
		end
	end

	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			state   <= mackbd_pkg::INIT;
			ps2_req <= 1'b0;
		end else begin
			state   <= state_next;
			ps2_req <= req_next;
		end
	end

	always_ff @(posedge sysclk) begin
		ps2_send_byte <= byte_next;
	end

	// The wire driver needs a gap between two send requests
	assert property (@(posedge sysclk) disable iff (reset) ps2_req |=> !ps2_req);

endmodule

/* scancode_map.sv */
module scancode_map (
	input  mackbd_pkg::scan_t     scan,
	output mackbd_pkg::mac_code_t code
);

	// Set 2 scan codes, bit 8 is the e0 prefix
	always_comb begin
		case (scan)
			9'h01c: code = 7'h00;   // a
			9'h01b: code = 7'h01;   // s
			9'h023: code = 7'h02;   // d
			9'h02b: code = 7'h03;   // f
			9'h033: code = 7'h04;   // h
			9'h034: code = 7'h05;   // g
			9'h01a: code = 7'h06;   // z
			9'h022: code = 7'h07;   // x
			9'h021: code = 7'h08;   // c
			9'h02a: code = 7'h09;   // v
			9'h032: code = 7'h0b;   // b
			9'h015: code = 7'h0c;   // q
			9'h01d: code = 7'h0d;   // w
			9'h024: code = 7'h0e;   // e
			9'h02d: code = 7'h0f;   // r
			9'h035: code = 7'h10;   // y
			9'h02c: code = 7'h11;   // t
			9'h016: code = 7'h12;   // 1
			9'h01e: code = 7'h13;   // 2
			9'h026: code = 7'h14;   // 3
			9'h025: code = 7'h15;   // 4
			9'h036: code = 7'h16;   // 6
			9'h02e: code = 7'h17;   // 5
			9'h046: code = 7'h19;   // 9
			9'h03d: code = 7'h1a;   // 7
			9'h03e: code = 7'h1c;   // 8
			9'h045: code = 7'h1d;   // 0
			9'h044: code = 7'h1f;   // o
			9'h03c: code = 7'h20;   // u
			9'h043: code = 7'h22;   // i
			9'h04d: code = 7'h23;   // p
			9'h05a: code = 7'h24;   // Enter
			9'h04b: code = 7'h25;   // l
			9'h03b: code = 7'h26;   // j
			9'h042: code = 7'h28;   // k
			9'h031: code = 7'h2d;   // n
			9'h03a: code = 7'h2e;   // m
			9'h00d: code = 7'h30;   // Tab
			9'h029: code = 7'h31;   // Space
			9'h066: code = 7'h33;   // Backspace
			9'h012: code = 7'h38;   // Left shift
			9'h059: code = 7'h38;   // Right shift
			9'h061: code = 7'h38;   // International key next to left shift
			9'h011: code = 7'h37;   // Left alt as command
			9'h111: code = 7'h37;   // Right alt as command
			9'h11f: code = 7'h3a;   // Windows key as option
			9'h058: code = 7'h39;   // Caps lock
			default: code = mackbd_pkg::MAC_KEY_NULL;
		endcase
	end

endmodule

/* scan_decoder.sv */
module scan_decoder (
	input  logic              sysclk,
	input  logic              reset,
	input  logic              ps2_strobe,
	input  mackbd_pkg::byte_t ps2_byte,
	input  logic              link_ready,
	output logic              capslock,
	key_if.driver             key
);

	logic                  accept;
	logic                  is_release;
	logic                  is_extend;
	logic                  is_caps;
	logic                  caps_filter;
	logic                  key_take;
	logic                  release_flag;
	logic                  extend_flag;
	mackbd_pkg::scan_t     scan;
	mackbd_pkg::mac_code_t map_code;

	assign accept      = link_ready && ps2_strobe;
	assign is_release  = (ps2_byte == mackbd_pkg::PS2_RELEASE);
	assign is_extend   = (ps2_byte == mackbd_pkg::PS2_EXTEND);
	assign is_caps     = (ps2_byte == mackbd_pkg::SCAN_CAPSLOCK);
	assign caps_filter = is_caps && capslock;       // Typematic repeats and the first release
	assign key_take    = accept && !is_release && !is_extend && !caps_filter;
	assign scan        = {extend_flag, ps2_byte};

	scancode_map scancode_map_i (
		.scan (scan),
		.code (map_code)
	);

	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			release_flag <= 1'b0;
			extend_flag  <= 1'b0;
			capslock     <= 1'b0;
		end else if (accept) begin
			if (is_release) begin
				release_flag <= 1'b1;
			end else if (is_extend) begin
				extend_flag <= 1'b1;
			end else begin
				release_flag <= 1'b0;
				extend_flag  <= 1'b0;
				if (is_caps && !release_flag) begin
					capslock <= ~capslock;          // Toggle on press only
				end
			end
		end
	end

	// One-deep latch, a key arriving while full is lost
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			key.pending <= 1'b0;
		end else if (key.pop) begin
			key.pending <= 1'b0;
		end else if (key_take) begin
			key.pending <= 1'b1;
		end
	end

	always_ff @(posedge sysclk) begin
		if (key_take && !key.pending) begin
			key.code     <= map_code;
			key.released <= release_flag;
		end
	end

	// A strobed byte is fully driven
	assert property (@(posedge sysclk) disable iff (reset)
		ps2_strobe |-> !$isunknown(ps2_byte));

endmodule

/* mac_responder.sv */
module mac_responder #(
	parameter int unsigned SHORT_TICKS = 4095,
	parameter int unsigned LONG_TICKS  = 4194303
) (
	input  logic              sysclk,
	input  logic              reset,
	input  mackbd_pkg::byte_t mac_cmd,
	input  logic              mac_cmd_strobe,
	key_if.consumer           key,
	output mackbd_pkg::byte_t mac_reply,
	output logic              mac_reply_strobe
);

	localparam int TIMER_W = $clog2(LONG_TICKS + 1);
	localparam logic [TIMER_W-1:0] SHORT_VAL = TIMER_W'(SHORT_TICKS);
	localparam logic [TIMER_W-1:0] LONG_VAL  = TIMER_W'(LONG_TICKS);

	logic [TIMER_W-1:0] pace_timer;
	logic               short_tick;
	logic               long_tick;
	logic               cmd_inquiry;
	logic               cmd_instant;
	logic               cmd_model;
	logic               cmd_test;
	logic               inquiry_armed;
	logic               pop_key;
	mackbd_pkg::byte_t  key_byte;

	// Latest command wins, an unknown byte leaves none latched
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			cmd_inquiry <= 1'b0;
			cmd_instant <= 1'b0;
			cmd_model   <= 1'b0;
			cmd_test    <= 1'b0;
		end else if (mac_cmd_strobe) begin
			cmd_inquiry <= (mac_cmd == mackbd_pkg::MAC_CMD_INQUIRY);
			cmd_instant <= (mac_cmd == mackbd_pkg::MAC_CMD_INSTANT);
			cmd_model   <= (mac_cmd == mackbd_pkg::MAC_CMD_MODEL);
			cmd_test    <= (mac_cmd == mackbd_pkg::MAC_CMD_TEST);
		end
	end

	// Pace timer restarts on each command and parks at the long tick
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			pace_timer <= '0;
		end else if (mac_cmd_strobe) begin
			pace_timer <= '0;
		end else if (!long_tick) begin
			pace_timer <= pace_timer + 1'b1;
		end
	end

	assign short_tick = (pace_timer == SHORT_VAL);
	assign long_tick  = (pace_timer == LONG_VAL);

	// Inquiry answers no earlier than the short tick
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			inquiry_armed <= 1'b0;
		end else if (mac_cmd_strobe || mac_reply_strobe) begin
			inquiry_armed <= 1'b0;
		end else if (short_tick) begin
			inquiry_armed <= cmd_inquiry;
		end
	end

	assign pop_key = (cmd_instant && short_tick) ||
	                 (inquiry_armed && long_tick) ||
	                 (inquiry_armed && key.pending);

	// Model and test replies also flush any waiting key
	assign key.pop = pop_key || cmd_model || cmd_test;

	assign mac_reply_strobe = ((cmd_model || cmd_test) && short_tick) || pop_key;

	always_comb begin
		key_byte = {key.code, 1'b1};
		key_byte[mackbd_pkg::RELEASE_BIT] = key.released;
	end

	always_comb begin
		if (cmd_test) begin
			mac_reply = mackbd_pkg::MAC_TEST_ACK;
		end else if (cmd_model) begin
			mac_reply = mackbd_pkg::MAC_MODEL_REPLY;
		end else if (key.pending) begin
			mac_reply = key_byte;
		end else begin
			mac_reply = mackbd_pkg::MAC_NULL;       // Nothing to report
		end
	end

	// Waiting key stays put until it is taken
	assert property (@(posedge sysclk) disable iff (reset)
		key.pending && $past(key.pending) |-> $stable(key.code) && $stable(key.released));

endmodule

/* ps2_mac_kbd.sv */
module ps2_mac_kbd #(
	parameter int unsigned SHORT_TICKS = 4095,
	parameter int unsigned LONG_TICKS  = 4194303
) (
	input  logic              sysclk,
	input  logic              reset,
	input  logic              ps2_strobe,
	input  mackbd_pkg::byte_t ps2_byte,
	input  logic              ps2_timeout,
	output logic              ps2_req,
	output mackbd_pkg::byte_t ps2_send_byte,
	input  mackbd_pkg::byte_t mac_cmd,
	input  logic              mac_cmd_strobe,
	output mackbd_pkg::byte_t mac_reply,
	output logic              mac_reply_strobe
);

	logic capslock;
	logic link_ready;

	key_if key_bus ();

	ps2_link_ctrl ps2_link_ctrl_i (
		.sysclk        (sysclk),
		.reset         (reset),
		.ps2_strobe    (ps2_strobe),
		.ps2_byte      (ps2_byte),
		.ps2_timeout   (ps2_timeout),
		.capslock      (capslock),
		.ps2_req       (ps2_req),
		.ps2_send_byte (ps2_send_byte),
		.link_ready    (link_ready)
	);

	scan_decoder scan_decoder_i (
		.sysclk     (sysclk),
		.reset      (reset),
		.ps2_strobe (ps2_strobe),
		.ps2_byte   (ps2_byte),
		.link_ready (link_ready),
		.capslock   (capslock),
		.key        (key_bus.driver)
	);

	mac_responder #(
		.SHORT_TICKS (SHORT_TICKS),
		.LONG_TICKS  (LONG_TICKS)
	) mac_responder_i (
		.sysclk           (sysclk),
		.reset            (reset),
		.mac_cmd          (mac_cmd),
		.mac_cmd_strobe   (mac_cmd_strobe),
		.key              (key_bus.consumer),
		.mac_reply        (mac_reply),
		.mac_reply_strobe (mac_reply_strobe)
	);

endmodule

/* tb_ps2_mac_kbd.sv */
module tb_ps2_mac_kbd;

	localparam int unsigned SHORT_TICKS = 20;
	localparam int unsigned LONG_TICKS  = 300;
	localparam int          N_RAND      = 13;   // Plain keys sit at the front of the table

	// Mapped subset, extended flag and scan byte on top, Mac key number below
	localparam logic [15:0] KEY_MAP [16] = '{
		{9'h01c, 7'h00}, {9'h01b, 7'h01}, {9'h015, 7'h0c}, {9'h016, 7'h12},
		{9'h045, 7'h1d}, {9'h03a, 7'h2e}, {9'h05a, 7'h24}, {9'h00d, 7'h30},
		{9'h029, 7'h31}, {9'h066, 7'h33}, {9'h012, 7'h38}, {9'h061, 7'h38},
		{9'h011, 7'h37}, {9'h111, 7'h37}, {9'h11f, 7'h3a}, {9'h058, 7'h39}
	};

	logic              sysclk;
	logic              reset;
	logic              ps2_strobe;
	mackbd_pkg::byte_t ps2_byte;
	logic              ps2_timeout;
	logic              ps2_req;
	mackbd_pkg::byte_t ps2_send_byte;
	mackbd_pkg::byte_t mac_cmd;
	logic              mac_cmd_strobe;
	mackbd_pkg::byte_t mac_reply;
	logic              mac_reply_strobe;

	mackbd_pkg::byte_t exp_q[$];                // Replies the Mac should see, in order
	int                reply_count = 0;
	logic [31:0]       lcg_state;
	logic              caps_on;
	logic              model_pending;           // One-deep key latch of the model
	mackbd_pkg::byte_t model_byte;
	mackbd_pkg::byte_t scan;

	ps2_mac_kbd #(
		.SHORT_TICKS (SHORT_TICKS),
		.LONG_TICKS  (LONG_TICKS)
	) ps2_mac_kbd_i (
		.sysclk           (sysclk),
		.reset            (reset),
		.ps2_strobe       (ps2_strobe),
		.ps2_byte         (ps2_byte),
		.ps2_timeout      (ps2_timeout),
		.ps2_req          (ps2_req),
		.ps2_send_byte    (ps2_send_byte),
		.mac_cmd          (mac_cmd),
		.mac_cmd_strobe   (mac_cmd_strobe),
		.mac_reply        (mac_reply),
		.mac_reply_strobe (mac_reply_strobe)
	);

	initial begin
		sysclk = 1'b0;
		forever #5 sysclk = ~sysclk;
	end

	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic mackbd_pkg::mac_code_t lookup_code(input logic [8:0] key);
		mackbd_pkg::mac_code_t code;
		int                    i;
		code = 7'h3d;                           // Null key
		for (i = 0; i < 16; i++) begin
			if (KEY_MAP[i][15:7] == key) begin
				code = KEY_MAP[i][6:0];
			end
		end
		return code;
	endfunction

	// Bit 8 says whether the key reaches the Mac at all
	function automatic logic [8:0] ref_reply(input logic ext, input logic rel,
		input logic caps, input mackbd_pkg::byte_t key);
		mackbd_pkg::byte_t reply;
		reply    = {lookup_code({ext, key}), 1'b1};
		reply[7] = rel;
		return {!(key == 8'h58 && caps), reply};
	endfunction

	// One PS/2 byte or a timeout, then the send request that follows it
	task automatic send_ps2(input logic tmo, input mackbd_pkg::byte_t b, input logic exp_req,
		input mackbd_pkg::byte_t exp_byte);
		@(posedge sysclk);
		#1;
		ps2_timeout = tmo;
		ps2_strobe  = !tmo;
		ps2_byte    = b;
		@(posedge sysclk);
		#1;
		ps2_timeout = 1'b0;
		ps2_strobe  = 1'b0;
		check("ps2_req", ps2_req, exp_req);
		if (exp_req) begin
			check("ps2_send_byte", ps2_send_byte, exp_byte);
		end
	endtask

	task automatic send_key(input logic ext, input logic rel, input mackbd_pkg::byte_t key);
		logic [8:0] r;
		r = ref_reply(ext, rel, caps_on, key);
		if (ext) begin
			send_ps2(1'b0, 8'he0, 1'b0, 8'h00);
		end
		if (rel) begin
			send_ps2(1'b0, 8'hf0, 1'b0, 8'h00);
		end
		send_ps2(1'b0, key, 1'b0, 8'h00);
		if (key == 8'h58 && !rel) begin
			caps_on = !caps_on;
		end
		if (r[8] && !model_pending) begin
			model_pending = 1'b1;               // A full latch drops the key
			model_byte    = r[7:0];
		end
	endtask

	task automatic start_cmd(input mackbd_pkg::byte_t cmd);
		@(posedge sysclk);
		#1;
		mac_cmd        = cmd;
		mac_cmd_strobe = 1'b1;
		@(posedge sysclk);
		#1;
		mac_cmd_strobe = 1'b0;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge sysclk);
	endtask

	task automatic wait_reply(input int limit);
		int start;
		int n;
		start = reply_count;
		n     = 0;
		while (reply_count == start) begin
			@(posedge sysclk);
			n++;
			if (n > limit) begin
				$display("timeout while waiting for a reply to the Mac");
				abort_run();
			end
		end
	endtask

	task automatic fetch_key();
		exp_q.push_back(model_pending ? model_byte : 8'h7b);
		model_pending = 1'b0;
		wait_reply(40);
		wait_cycles(3);
	endtask

	task automatic random_scan(output mackbd_pkg::byte_t key);
		lcg_state = lcg_next(lcg_state);
		key       = KEY_MAP[lcg_state[23:16] % N_RAND][14:7];
	endtask

	// Every reply strobe must match the next expected byte
	always @(negedge sysclk) begin
		if (!reset && mac_reply_strobe) begin
			if (exp_q.size() == 0) begin
				$display("a reply %h reached the Mac when none was expected", mac_reply);
				abort_run();
			end else begin
				check("mac_reply", mac_reply, exp_q.pop_front());
				reply_count++;
			end
		end
	end

	initial begin
		reset          = 1'b1;
		ps2_strobe     = 1'b0;
		ps2_byte       = 8'h00;
		ps2_timeout    = 1'b0;
		mac_cmd        = 8'h00;
		mac_cmd_strobe = 1'b0;
		lcg_state      = 32'h492b2f2b;
		caps_on        = 1'b0;
		model_pending  = 1'b0;
		model_byte     = 8'h00;
		repeat (5) @(posedge sysclk);
		#1;
		reset = 1'b0;
		check("ps2_req", ps2_req, 1'b0);
		check("mac_reply_strobe", mac_reply_strobe, 1'b0);

		// Bring-up with a bad ack in LED_CMD and a retry
		send_ps2(1'b1, 8'h00, 1'b1, 8'hff);
		send_ps2(1'b0, 8'haa, 1'b1, 8'hed);
		send_ps2(1'b0, 8'h55, 1'b1, 8'hff);
		send_ps2(1'b0, 8'haa, 1'b1, 8'hed);
		send_ps2(1'b0, 8'hfa, 1'b1, 8'h02 | {5'd0, caps_on, 2'd0});
		send_ps2(1'b0, 8'hfa, 1'b0, 8'h00);

		exp_q.push_back(8'h03);
		start_cmd(mackbd_pkg::MAC_CMD_MODEL);
		wait_reply(60);
		wait_cycles(30);
		exp_q.push_back(8'h7d);
		start_cmd(mackbd_pkg::MAC_CMD_TEST);
		wait_reply(60);
		wait_cycles(30);
		start_cmd(mackbd_pkg::MAC_CMD_MODEL);   // Overtaken before its reply
		wait_cycles(5);
		exp_q.push_back(8'h7d);
		start_cmd(mackbd_pkg::MAC_CMD_TEST);
		wait_reply(60);
		wait_cycles(30);

		repeat (4) begin
			random_scan(scan);
			start_cmd(mackbd_pkg::MAC_CMD_INSTANT);
			send_key(1'b0, 1'b0, scan);
			fetch_key();
			start_cmd(mackbd_pkg::MAC_CMD_INSTANT);
			send_key(1'b0, 1'b1, scan);
			fetch_key();
		end
		start_cmd(mackbd_pkg::MAC_CMD_INSTANT);
		fetch_key();

		// Inquiry answers null only at the long tick
		start_cmd(mackbd_pkg::MAC_CMD_INQUIRY);
		wait_cycles(LONG_TICKS - 20);
		exp_q.push_back(8'h7b);
		wait_reply(60);
		wait_cycles(30);
		start_cmd(mackbd_pkg::MAC_CMD_INQUIRY);
		wait_cycles(SHORT_TICKS + 5);
		random_scan(scan);
		send_key(1'b0, 1'b0, scan);
		fetch_key();

		// Caps lock press, release, press, release
		repeat (2) begin
			start_cmd(mackbd_pkg::MAC_CMD_INSTANT);
			send_key(1'b0, 1'b0, 8'h58);
			fetch_key();
			start_cmd(mackbd_pkg::MAC_CMD_INSTANT);
			send_key(1'b0, 1'b1, 8'h58);
			fetch_key();
		end
		start_cmd(mackbd_pkg::MAC_CMD_INSTANT);
		send_key(1'b1, 1'b0, 8'h11);
		fetch_key();
		start_cmd(mackbd_pkg::MAC_CMD_INSTANT);
		send_key(1'b1, 1'b1, 8'h11);
		fetch_key();

		start_cmd(mackbd_pkg::MAC_CMD_INSTANT);
		send_key(1'b0, 1'b0, 8'h1c);
		send_key(1'b0, 1'b0, 8'h29);            // Lost behind the pending key
		fetch_key();
		start_cmd(mackbd_pkg::MAC_CMD_INSTANT);
		fetch_key();

		if (exp_q.size() != 0) begin
			$display("replies were still expected at the end of the run");
			abort_run();
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

/* vlog.f */
mackbd_pkg.sv
key_if.sv
ps2_link_ctrl.sv
scancode_map.sv
scan_decoder.sv
mac_responder.sv
ps2_mac_kbd.sv
tb_ps2_mac_kbd.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the PS/2 to Mac keyboard testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module tb_ps2_mac_kbd -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx '>>> PASS' "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
